/* files.f */
+incdir+common
common/gremlin_pkg.sv
src/host_port.sv
src/slot_timer.sv
scheduler/transfer_scheduler.sv
src/gremlin_top.sv
testbench/tb_clock_gen.sv
testbench/tb_gremlin.sv

/* Bender.yml */
package:
  name: gremlin

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/gremlin_pkg.sv
      - src/host_port.sv
      - src/slot_timer.sv
      - scheduler/transfer_scheduler.sv
      - src/gremlin_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_gremlin.sv

/* testbench/tb_gremlin.sv */
`timescale 1ns/10ps
`include "gremlin_consts.svh"

module tb_gremlin;

  import gremlin_pkg::*;

  localparam int NUM_XFERS      = 18;
  localparam int PERIOD         = `GREMLIN_SMALL_PERIOD;
  localparam int LAUNCH_LAT     = 2;                       // slot edge to request
  localparam int SAMPLE_DELAY   = 25;                      // into the low clock phase
  localparam int TIMEOUT_CYCLES = (NUM_XFERS / 2 + 3) * PERIOD;

  logic                             CLK;
  logic                             RST;
  logic                             cmd_valid_i;
  host_cmd_t                        cmd_i;
  logic                             cmd_ready_o;
  logic                             rd_req_i;
  lane_e                            rd_lane_i;
  status_t                          rd_data_o;
  logic                             rd_valid_o;
  issue_t                           issue_o;
  logic                             blck_issue_o;
  logic [1:0]                       mcu_request_o;
  logic [1:0]                       mcu_grant_i;
  logic                             blck_working_i;
  logic [`GREMLIN_COUNT_W-1:0]      blck_count_sent_i;
  logic                             blck_irq_i;
  logic                             blck_abrupt_stop_i;
  logic                             blck_dev_err_i;
  logic [`GREMLIN_NUM_SECTIONS-1:0] en_stb_o;
  logic                             mcu_refresh_strobe_o;

  int          error_cnt    = 0;
  int          cycle_cnt    = 0;                           // rising edges since reset
  int          done_cnt     = 0;
  int          refresh_cnt  = 0;
  logic        refresh_prev = 1'b0;
  logic [31:0] lfsr_q;

  descriptor_t                 exp0_q[$];                  // written but not yet launched
  descriptor_t                 exp1_q[$];
  descriptor_t                 desc_tab[NUM_XFERS];
  logic [2:0]                  gnt_dly[NUM_XFERS];
  int                          work_len[NUM_XFERS];
  logic [`GREMLIN_COUNT_W-1:0] sent_tab[NUM_XFERS];
  logic                        irq_tab[NUM_XFERS];
  logic                        abrupt_tab[NUM_XFERS];
  logic                        dev_err_tab[NUM_XFERS];

  tb_clock_gen #(.PERIOD_NS(100), .RST_CYCLES(8)) tb_clock_gen_i (
    .clk_o (CLK),
    .rst_o (RST)
  );

  gremlin_top gremlin_top_i (
    .CLK                  (CLK),
    .RST                  (RST),
    .cmd_valid_i          (cmd_valid_i),
    .cmd_i                (cmd_i),
    .cmd_ready_o          (cmd_ready_o),
    .rd_req_i             (rd_req_i),
    .rd_lane_i            (rd_lane_i),
    .rd_data_o            (rd_data_o),
    .rd_valid_o           (rd_valid_o),
    .issue_o              (issue_o),
    .blck_issue_o         (blck_issue_o),
    .mcu_request_o        (mcu_request_o),
    .mcu_grant_i          (mcu_grant_i),
    .blck_working_i       (blck_working_i),
    .blck_count_sent_i    (blck_count_sent_i),
    .blck_irq_i           (blck_irq_i),
    .blck_abrupt_stop_i   (blck_abrupt_stop_i),
    .blck_dev_err_i       (blck_dev_err_i),
    .en_stb_o             (en_stb_o),
    .mcu_refresh_strobe_o (mcu_refresh_strobe_o)
  );

  // ------------------------------
  // random source and references
  // ------------------------------

  // taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] draw_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic issue_t expected_issue(descriptor_t d);
    issue_t     e;
    logic [2:0] data_path;
    data_path    = d.on_data ? 3'b010 : 3'b001;            // one-hot of on_data
    e.start      = d.start;
    e.count_req  = d.count_req;
    e.section    = d.section;
    e.page_addr  = d.page_addr;
    e.care_int   = d.care_int;
    e.rst_mvblck = d.rd_mem ? 2'b10 : 2'b01;
    if (d.rd_mem)
    begin
      e.swch_isel = 3'b100;
      e.swch_osel = data_path;
    end
    else
    begin
      e.swch_isel = data_path;
      e.swch_osel = 3'b100;
    end
    return e;
  endfunction

  function automatic status_t expected_status(logic [`GREMLIN_COUNT_W-1:0] sent, logic irq,
                                              logic abrupt, logic dev_err);
    status_t s;
    s.count_sent = sent;
    s.irq        = irq;
    s.abort      = abrupt | dev_err;
    return s;
  endfunction

  // lane 0 slots while the big carousel is odd
  function automatic int expected_refresh(int cycles);
    int n;
    n = 0;
    for (int p = 0; p * PERIOD < cycles; p++)
    begin
      if (p % 2 == 1)
        n++;
    end
    return n;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_issue(string name, issue_t exp, issue_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      error_cnt++;
    end
  endtask

  task automatic check_status(string name, status_t exp, status_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      error_cnt++;
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act)
    begin
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      error_cnt++;
    end
  endtask

  // holds valid until the port takes the descriptor
  task automatic write_desc(lane_e lane, descriptor_t d, bit busy);
    int exp_phase;
    exp_phase = ((lane == LANE0) ? `GREMLIN_LANE0_SLOT : `GREMLIN_LANE1_SLOT) + LAUNCH_LAT;
    @(negedge CLK);
    cmd_i.lane  = lane;
    cmd_i.desc  = d;
    cmd_valid_i = 1'b1;
    #(SAMPLE_DELAY);
    if (busy)
      check_count("ready_while_pending", 0, int'(cmd_ready_o));
    while (!cmd_ready_o)
    begin
      @(negedge CLK);
      #(SAMPLE_DELAY);
    end
    if (busy)
      check_count("ready_after_take", exp_phase, cycle_cnt % PERIOD);
    if (lane == LANE0)
      exp0_q.push_back(d);
    else
      exp1_q.push_back(d);
    @(negedge CLK);
    cmd_valid_i = 1'b0;                                    // taken on the edge before
  endtask

  always @(posedge CLK)
  begin
    if (RST)
      cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge CLK)
  begin
    if (RST && (mcu_refresh_strobe_o != refresh_prev))
      refresh_cnt++;
    refresh_prev = mcu_refresh_strobe_o;
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial
  begin : stimulus
    descriptor_t d;
    lane_e       lane;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    lfsr_q      = 32'h38;
    for (int i = 0; i < NUM_XFERS; i++)
    begin
      d.page_addr    = `GREMLIN_PAGE_W'(draw_bits(`GREMLIN_PAGE_W));
      d.start        = `GREMLIN_START_W'(draw_bits(`GREMLIN_START_W));
      d.count_req    = `GREMLIN_COUNT_W'(draw_bits(`GREMLIN_COUNT_W));
      d.section      = `GREMLIN_SECTION_W'(draw_bits(`GREMLIN_SECTION_W));
      d.rd_mem       = 1'(draw_bits(1));
      d.on_data      = 1'(draw_bits(1));
      d.care_int     = 1'(draw_bits(1));
      desc_tab[i]    = d;
      gnt_dly[i]     = 3'(draw_bits(3));                   // 0 to 7 cycles
      work_len[i]    = int'(draw_bits(4)) % 15 + 1;        // 1 to 15 cycles
      sent_tab[i]    = `GREMLIN_COUNT_W'(draw_bits(`GREMLIN_COUNT_W));
      irq_tab[i]     = 1'(draw_bits(1));
      abrupt_tab[i]  = 1'(draw_bits(1));
      dev_err_tab[i] = 1'(draw_bits(1));
    end
    wait (RST);
    // every write after the first two meets a full holding register
    for (int i = 0; i < NUM_XFERS; i++)
    begin
      lane = (i == 0 || (i > 1 && i % 2 == 1)) ? LANE0 : LANE1;
      write_desc(lane, desc_tab[i], i > 1);
    end
    wait (done_cnt == NUM_XFERS);
    @(negedge CLK);
    while (cycle_cnt % PERIOD != PERIOD - 2)
      @(negedge CLK);
    #(SAMPLE_DELAY);
    check_count("refresh_strobes", expected_refresh(cycle_cnt), refresh_cnt);
    $display("errors: %0d", error_cnt);
    if (error_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // ------------------------------
  // memory controller and block mover
  // ------------------------------

  initial
  begin : mover_model
    logic issue_seen;
    mcu_grant_i        = '0;
    blck_working_i     = 1'b0;
    blck_count_sent_i  = '0;
    blck_irq_i         = 1'b0;
    blck_abrupt_stop_i = 1'b0;
    blck_dev_err_i     = 1'b0;
    wait (RST);
    for (int n = 0; n < NUM_XFERS; n++)
    begin
      @(negedge CLK);
      while (mcu_request_o == 2'b00)
        @(negedge CLK);
      repeat (gnt_dly[n]) @(negedge CLK);
      issue_seen  = blck_issue_o;
      mcu_grant_i = mcu_request_o;
      @(negedge CLK);
      while (blck_issue_o == issue_seen)
        @(negedge CLK);
      mcu_grant_i        = '0;
      blck_working_i     = 1'b1;
      blck_count_sent_i  = sent_tab[n];
      blck_irq_i         = irq_tab[n];
      blck_abrupt_stop_i = abrupt_tab[n];
      blck_dev_err_i     = dev_err_tab[n];
      repeat (work_len[n]) @(negedge CLK);
      blck_working_i = 1'b0;                               // falling edge ends transfer
      @(negedge CLK);
      while (mcu_request_o != 2'b00)
        @(negedge CLK);
    end
  end

  // ------------------------------
  // checking
  // ------------------------------

  initial
  begin : compare_results
    descriptor_t d;
    lane_e       lane;
    int          phase;
    logic [`GREMLIN_NUM_SECTIONS-1:0] stb_exp;
    rd_req_i  = 1'b0;
    rd_lane_i = LANE0;
    stb_exp   = '0;
    wait (RST);
    for (int n = 0; n < NUM_XFERS; n++)
    begin
      @(negedge CLK);
      while (mcu_request_o == 2'b00)
        @(negedge CLK);
      phase = cycle_cnt % PERIOD;
      lane  = (phase == `GREMLIN_LANE1_SLOT + LAUNCH_LAT) ? LANE1 : LANE0;
      if (phase != `GREMLIN_LANE0_SLOT + LAUNCH_LAT && lane == LANE0)
      begin
        $display("request raised at carousel position %0d, outside both lane slots", phase);
        error_cnt++;
      end
      if (lane == LANE0 && exp0_q.size() > 0)
        d = exp0_q.pop_front();
      else if (lane == LANE1 && exp1_q.size() > 0)
        d = exp1_q.pop_front();
      else
      begin
        $display("transfer started on lane %0d with no descriptor written", lane);
        error_cnt++;
        d = '0;
      end
      check_issue("issue_fields", expected_issue(d), issue_o);
      check_count("request_onehot", d.on_data ? 2 : 1, mcu_request_o);
      check_count("section_strobe_idle", stb_exp, en_stb_o);
      check_count("issue_toggle_idle", n % 2, int'(blck_issue_o));  // one toggle per transfer
      @(negedge CLK);
      while (mcu_request_o != 2'b00)
        @(negedge CLK);
      stb_exp[d.section] = ~stb_exp[d.section];
      check_count("section_strobe", stb_exp, en_stb_o);
      check_count("issue_toggle", (n + 1) % 2, int'(blck_issue_o));
      check_count("rst_mvblck_cleared", 0, int'(issue_o.rst_mvblck));
      rd_req_i  = 1'b1;
      rd_lane_i = lane;
      @(negedge CLK);
      rd_req_i = 1'b0;
      check_count("read_valid", 1, rd_valid_o);
      check_status("status_read", expected_status(sent_tab[n], irq_tab[n], abrupt_tab[n],
                                                  dev_err_tab[n]), rd_data_o);
      @(negedge CLK);
      check_count("read_valid_pulse", 0, rd_valid_o);
      done_cnt = n + 1;
    end
  end

  initial
  begin : watchdog
    wait (RST);
    while (cycle_cnt < TIMEOUT_CYCLES)
      @(negedge CLK);
    $display("Timeout after %0d cycles with %0d of %0d transfers done",
             cycle_cnt, done_cnt, NUM_XFERS);
    error_cnt++;
    $display("errors: %0d", error_cnt);
    $display("Test failed");
    $finish;
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // active low, released on a falling edge
  initial
  begin
    rst_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b1;
  end

endmodule

/* src/gremlin_top.sv */
`timescale 1ns/10ps
`include "gremlin_consts.svh"

module gremlin_top (
  input  logic                             CLK,
  input  logic                             RST,
  // host write
  input  logic                             cmd_valid_i,
  input  gremlin_pkg::host_cmd_t           cmd_i,
  output logic                             cmd_ready_o,
  // host read
  input  logic                             rd_req_i,
  input  gremlin_pkg::lane_e               rd_lane_i,
  output gremlin_pkg::status_t             rd_data_o,
  output logic                             rd_valid_o,
  // block mover and memory controller
  output gremlin_pkg::issue_t              issue_o,
  output logic                             blck_issue_o,
  output logic [1:0]                       mcu_request_o,
  input  logic [1:0]                       mcu_grant_i,
  input  logic                             blck_working_i,
  input  logic [`GREMLIN_COUNT_W-1:0]      blck_count_sent_i,
  input  logic                             blck_irq_i,
  input  logic                             blck_abrupt_stop_i,
  input  logic                             blck_dev_err_i,
  // status
  output logic [`GREMLIN_NUM_SECTIONS-1:0] en_stb_o,
  output logic                             mcu_refresh_strobe_o
);

  import gremlin_pkg::*;

  logic [`GREMLIN_NUM_LANES-1:0]        pend_valid;
  descriptor_t [`GREMLIN_NUM_LANES-1:0] pend_desc;
  logic [`GREMLIN_NUM_LANES-1:0]        take;
  status_t [`GREMLIN_NUM_LANES-1:0]     lane_status;
  logic slot0;
  logic slot1;
  logic refresh_slot;

  host_port host_port_i (
    .CLK           (CLK),
    .RST           (RST),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_ready_o   (cmd_ready_o),
    .rd_req_i      (rd_req_i),
    .rd_lane_i     (rd_lane_i),
    .rd_data_o     (rd_data_o),
    .rd_valid_o    (rd_valid_o),
    .take_i        (take),
    .lane_status_i (lane_status),
    .pend_valid_o  (pend_valid),
    .pend_desc_o   (pend_desc)
  );

  slot_timer slot_timer_i (
    .CLK            (CLK),
    .RST            (RST),
    .slot0_o        (slot0),
    .slot1_o        (slot1),
    .refresh_slot_o (refresh_slot)
  );

  transfer_scheduler transfer_scheduler_i (
    .CLK                  (CLK),
    .RST                  (RST),
    .slot0_i              (slot0),
    .slot1_i              (slot1),
    .refresh_slot_i       (refresh_slot),
    .pend_valid_i         (pend_valid),
    .pend_desc_i          (pend_desc),
    .take_o               (take),
    .lane_status_o        (lane_status),
    .issue_o              (issue_o),
    .blck_issue_o         (blck_issue_o),
    .mcu_request_o        (mcu_request_o),
    .mcu_grant_i          (mcu_grant_i),
    .blck_working_i       (blck_working_i),
    .blck_count_sent_i    (blck_count_sent_i),
    .blck_irq_i           (blck_irq_i),
    .blck_abrupt_stop_i   (blck_abrupt_stop_i),
    .blck_dev_err_i       (blck_dev_err_i),
    .en_stb_o             (en_stb_o),
    .mcu_refresh_strobe_o (mcu_refresh_strobe_o)
  );

endmodule

/* scheduler/transfer_scheduler.sv */
`timescale 1ns/10ps
`include "gremlin_consts.svh"

module transfer_scheduler (
  input  logic                                              CLK,
  input  logic                                              RST,
  // slot timer
  input  logic                                              slot0_i,
  input  logic                                              slot1_i,
  input  logic                                              refresh_slot_i,
  // host port
  input  logic [`GREMLIN_NUM_LANES-1:0]                     pend_valid_i,
  input  gremlin_pkg::descriptor_t [`GREMLIN_NUM_LANES-1:0] pend_desc_i,
  output logic [`GREMLIN_NUM_LANES-1:0]                     take_o,
  output gremlin_pkg::status_t [`GREMLIN_NUM_LANES-1:0]     lane_status_o,
  // issue side
  output gremlin_pkg::issue_t                               issue_o,
  output logic                                              blck_issue_o,
  output logic [1:0]                                        mcu_request_o,
  input  logic [1:0]                                        mcu_grant_i,
  // block mover
  input  logic                                              blck_working_i,
  input  logic [`GREMLIN_COUNT_W-1:0]                       blck_count_sent_i,
  input  logic                                              blck_irq_i,
  input  logic                                              blck_abrupt_stop_i,
  input  logic                                              blck_dev_err_i,
  // status
  output logic [`GREMLIN_NUM_SECTIONS-1:0]                  en_stb_o,
  output logic                                              mcu_refresh_strobe_o
);

  import gremlin_pkg::*;

  sched_state_e state_q;
  lane_e        lane_q;                                    // lane in flight
  descriptor_t  desc_q;                                    // captured at launch
  logic         launch_q;                                  // issue mapping next edge
  logic         working_q;                                 // for falling-edge detect
  logic [`GREMLIN_REFRESH_W-1:0] refresh_debt_q;

  logic    idle;
  logic    launch0;
  logic    launch1;
  logic    launch;
  logic    granted;
  logic    work_done;
  logic    refresh_go;
  status_t done_status;

  // descriptor to switch / block mover coding
  function automatic issue_t map_issue(descriptor_t d);
    issue_t                    iss;
    logic [`GREMLIN_SEL_W-1:0] path;
    path           = {1'b0, d.on_data, ~d.on_data};
    iss.start      = d.start;
    iss.count_req  = d.count_req;
    iss.section    = d.section;
    iss.page_addr  = d.page_addr;
    iss.care_int   = d.care_int;
    iss.rst_mvblck = {d.rd_mem, ~d.rd_mem};
    iss.swch_isel  = d.rd_mem ? 3'b100 : path;             // codes swap with direction
    iss.swch_osel  = d.rd_mem ? path : 3'b100;
    return iss;
  endfunction

  // ------------------------------
  // decode
  // ------------------------------

  assign idle       = (state_q == S_IDLE) && !launch_q;
  assign launch0    = idle && slot0_i && pend_valid_i[LANE0];
  assign launch1    = idle && slot1_i && pend_valid_i[LANE1];
  assign launch     = launch0 || launch1;
  assign granted    = (state_q == S_REQUEST) && |(mcu_request_o & mcu_grant_i);
  assign work_done  = (state_q == S_BUSY) && working_q && !blck_working_i;
  assign refresh_go = idle && (refresh_debt_q != '0);

  assign done_status.count_sent = blck_count_sent_i;
  assign done_status.irq        = blck_irq_i;
  assign done_status.abort      = blck_abrupt_stop_i || blck_dev_err_i;

  always_ff @(posedge CLK)
  begin
    if (launch)
      desc_q <= launch1 ? pend_desc_i[LANE1] : pend_desc_i[LANE0];
  end

  // ------------------------------
  // dispatch FSM
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state_q              <= S_IDLE;
      lane_q               <= LANE0;
      launch_q             <= 1'b0;
      working_q            <= 1'b0;
      take_o               <= '0;
      issue_o              <= '0;
      mcu_request_o        <= '0;
      blck_issue_o         <= 1'b0;
      lane_status_o        <= '0;
      en_stb_o             <= '0;
      refresh_debt_q       <= '0;
      mcu_refresh_strobe_o <= 1'b0;
    end
    else
    begin
      take_o    <= {launch1, launch0};                     // one-cycle, empties holding reg
      launch_q  <= launch;
      working_q <= blck_working_i;

      if (launch)
        lane_q <= launch1 ? LANE1 : LANE0;

      if (launch_q)
      begin
        issue_o       <= map_issue(desc_q);
        mcu_request_o <= {desc_q.on_data, ~desc_q.on_data};
        state_q       <= S_REQUEST;
      end

      if (granted)
      begin
        blck_issue_o <= ~blck_issue_o;                     // toggle starts the mover
        state_q      <= S_BUSY;
      end

      if (work_done)
      begin
        mcu_request_o                  <= '0;
        issue_o.rst_mvblck             <= '0;
        lane_status_o[lane_q]          <= done_status;
        en_stb_o[issue_o.section]      <= ~en_stb_o[issue_o.section];
        state_q                        <= S_IDLE;
      end

      // refresh debt, paid back only while nothing is in flight
      case ({refresh_slot_i, refresh_go})
        2'b10:   refresh_debt_q <= refresh_debt_q + 1'b1;
        2'b01:   refresh_debt_q <= refresh_debt_q - 1'b1;
        default: refresh_debt_q <= refresh_debt_q;
      endcase

      if (refresh_go)
        mcu_refresh_strobe_o <= ~mcu_refresh_strobe_o;
    end
  end

endmodule

/* src/slot_timer.sv */
`timescale 1ns/10ps
`include "gremlin_consts.svh"

module slot_timer (
  input  logic CLK,
  input  logic RST,
  output logic slot0_o,
  output logic slot1_o,
  output logic refresh_slot_o
);

  logic [`GREMLIN_SMALL_W-1:0]   small_q;
  logic [`GREMLIN_BIG_WIDTH-1:0] big_q;
  logic small_wrap;

  assign small_wrap = (small_q == `GREMLIN_SMALL_W'(`GREMLIN_SMALL_PERIOD - 1));

  // ------------------------------
  // carousels
  // ------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      small_q <= '0;
      big_q   <= '0;
    end
    else if (small_wrap)
    begin
      small_q <= '0;
      big_q   <= big_q + 1'b1;                             // one step per small round
    end
    else
    begin
      small_q <= small_q + 1'b1;
    end
  end

  // ------------------------------
  // slot decode
  // ------------------------------

  assign slot0_o = (small_q == `GREMLIN_SMALL_W'(`GREMLIN_LANE0_SLOT));
  assign slot1_o = (small_q == `GREMLIN_SMALL_W'(`GREMLIN_LANE1_SLOT));

  // every other round the lane 0 slot also carries a refresh
  assign refresh_slot_o = slot0_o && big_q[0];

endmodule

/* src/host_port.sv */
`timescale 1ns/10ps
`include "gremlin_consts.svh"

module host_port (
  input  logic                                              CLK,
  input  logic                                              RST,
  // host write
  input  logic                                              cmd_valid_i,
  input  gremlin_pkg::host_cmd_t                            cmd_i,
  output logic                                              cmd_ready_o,
  // host read
  input  logic                                              rd_req_i,
  input  gremlin_pkg::lane_e                                rd_lane_i,
  output gremlin_pkg::status_t                              rd_data_o,
  output logic                                              rd_valid_o,
  // scheduler side
  input  logic [`GREMLIN_NUM_LANES-1:0]                     take_i,
  input  gremlin_pkg::status_t [`GREMLIN_NUM_LANES-1:0]     lane_status_i,
  output logic [`GREMLIN_NUM_LANES-1:0]                     pend_valid_o,
  output gremlin_pkg::descriptor_t [`GREMLIN_NUM_LANES-1:0] pend_desc_o
);

  import gremlin_pkg::*;

  logic [`GREMLIN_NUM_LANES-1:0] pend_q;                   // holding register full
  descriptor_t [`GREMLIN_NUM_LANES-1:0] desc_q;
  logic accept;

  // ------------------------------
  // write side
  // ------------------------------

  // ready only towards a lane whose holding register is free
  assign cmd_ready_o = !pend_q[cmd_i.lane];
  assign accept      = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      pend_q <= '0;
    end
    else
    begin
      for (int l = 0; l < `GREMLIN_NUM_LANES; l++)
      begin
        if (take_i[l])
          pend_q[l] <= 1'b0;                               // scheduler took it
        else if (accept && (cmd_i.lane == lane_e'(l)))
          pend_q[l] <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (accept)
      desc_q[cmd_i.lane] <= cmd_i.desc;
  end

  assign pend_valid_o = pend_q;
  assign pend_desc_o  = desc_q;

  // ------------------------------
  // read side
  // ------------------------------

  // Fixed one-cycle latency. The data register is only loaded on a request,
  // so rd_data_o holds the last answer between reads.
  always_ff @(posedge CLK)
  begin
    if (!RST)
      rd_valid_o <= 1'b0;
    else
      rd_valid_o <= rd_req_i;
  end

  always_ff @(posedge CLK)
  begin
    if (rd_req_i)
      rd_data_o <= lane_status_i[rd_lane_i];               // status of last completion
  end

endmodule

/* common/gremlin_pkg.sv */
`include "gremlin_consts.svh"

package gremlin_pkg;

  // ------------------------------
  // enums
  // ------------------------------

  typedef enum logic {
    LANE0 = 1'b0,
    LANE1 = 1'b1
  } lane_e;

  typedef enum logic [1:0] {
    S_IDLE    = 2'd0,                  // waiting for a slot
    S_REQUEST = 2'd1,                  // memory request out, waiting for grant
    S_BUSY    = 2'd2                   // block mover running
  } sched_state_e;

  // ------------------------------
  // structs
  // ------------------------------

  // one complete transfer as written by the host
  typedef struct packed {
    logic [`GREMLIN_PAGE_W-1:0]    page_addr;
    logic [`GREMLIN_START_W-1:0]   start;
    logic [`GREMLIN_COUNT_W-1:0]   count_req;
    logic [`GREMLIN_SECTION_W-1:0] section;
    logic                          rd_mem;     // memory is the source
    logic                          on_data;    // data side of the memory
    logic                          care_int;
  } descriptor_t;

  typedef struct packed {
    lane_e       lane;
    descriptor_t desc;
  } host_cmd_t;

  // what goes out to the block mover, switch and memory controller
  typedef struct packed {
    logic [`GREMLIN_START_W-1:0]   start;
    logic [`GREMLIN_COUNT_W-1:0]   count_req;
    logic [`GREMLIN_SECTION_W-1:0] section;
    logic [`GREMLIN_PAGE_W-1:0]    page_addr;
    logic                          care_int;
    logic [1:0]                    rst_mvblck;  // bit 1 is rd_mem
    logic [`GREMLIN_SEL_W-1:0]     swch_isel;
    logic [`GREMLIN_SEL_W-1:0]     swch_osel;
  } issue_t;

  // result of the last finished transfer of a lane
  typedef struct packed {
    logic [`GREMLIN_COUNT_W-1:0] count_sent;
    logic                        irq;
    logic                        abort;       // abrupt stop or device error
  } status_t;

endpackage

/* common/gremlin_consts.svh */
`ifndef GREMLIN_CONSTS_SVH
`define GREMLIN_CONSTS_SVH

// ------------------------------
// carousel timing
// ------------------------------

`define GREMLIN_SMALL_PERIOD 192      // small carousel length in cycles
`define GREMLIN_SMALL_W      8        // small counter width
`define GREMLIN_BIG_WIDTH    4        // big carousel width

`define GREMLIN_LANE0_SLOT   0        // small carousel position of lane 0
`define GREMLIN_LANE1_SLOT   96       // half a period later

// ------------------------------
// descriptor fields
// ------------------------------

`define GREMLIN_PAGE_W       20       // memory page address
`define GREMLIN_START_W      12       // block start offset
`define GREMLIN_COUNT_W      6        // requested / sent word count
`define GREMLIN_SECTION_W    2
`define GREMLIN_SEL_W        3        // switch input / output select codes

// ------------------------------
// sizes
// ------------------------------

`define GREMLIN_NUM_LANES    2
`define GREMLIN_NUM_SECTIONS 4        // one en_stb bit per section
`define GREMLIN_REFRESH_W    4        // pending refresh counter

`endif
